// ==== verification/harness_stimulus.txt ====
# name opcode src_a src_b dst read_ef_a read_ef_b write_ef read_data_a read_data_b
# then expected write_data rden_a rden_b wren exec_count stall_count, all hex, port 0 lowest
add_basic 0 1 2 3 f f f 44332211 88776655 99 2 4 8 01 00
add_wrap 0 3 3 0 f f f f0332211 20776655 10 8 8 1 02 00
sub_basic 1 0 1 2 f f f 44332250 88771055 40 1 2 4 03 00
sub_wrap 1 2 0 1 f f f 44052211 88776630 d5 4 1 2 04 00
and_basic 2 1 3 0 f f f 4433cc11 aa776655 88 2 8 1 05 00
xor_basic 3 3 1 3 f f f 5a332211 88770f55 55 8 2 8 06 00
stall_src_a_empty 0 2 0 1 b f f 44332211 88776655 55 0 0 0 06 01
stall_src_b_empty 1 0 3 2 f 7 f 44332211 88776655 55 0 0 0 06 02
stall_dst_full 3 1 1 2 f f b 44332211 88776655 55 0 0 0 06 03
ready_other_ports_empty 0 0 0 0 1 1 1 00000007 00000009 10 1 1 1 07 03
sel_port_0 3 0 3 0 f f f 40302010 04030201 14 1 8 1 08 03
sel_port_1 3 1 2 1 f f f 40302010 04030201 23 2 4 2 09 03
sel_port_2 3 2 1 2 f f f 40302010 04030201 32 4 2 4 0a 03
sel_port_3 3 3 0 3 f f f 40302010 04030201 41 8 1 8 0b 03
stall_all_empty 0 0 0 0 0 0 0 40302010 04030201 41 0 0 0 0b 04
add_wrap_zero 0 2 2 1 f f f 44ff2211 88016655 00 4 4 2 0c 04

// ==== files.f ====
hw/harness_pkg.sv
hw/harness_input_register.sv
hw/harness_output_register.sv
hw/triadic_alu.sv
hw/io_port_core.sv
hw/test_harness.sv
verification/tb_test_harness.sv

// ==== verification/tb_test_harness.sv ====
`timescale 1ns/1ps

module tb_test_harness;

    logic clock;
    logic arst_n;
    logic test_in;
    logic shift_en;
    logic update;
    logic capture;
    logic test_out;

    // One entry per stimulus line
    string                               name_q[$];
    logic [harness_pkg::input_width-1:0] stim_q[$];
    logic [7:0]                          exp_write_data_q[$];
    logic [3:0]                          exp_rden_a_q[$];
    logic [3:0]                          exp_rden_b_q[$];
    logic [3:0]                          exp_wren_q[$];
    logic [7:0]                          exp_exec_q[$];
    logic [7:0]                          exp_stall_q[$];

    int error_count     = 0;
    int check_count     = 0;
    int watchdog_cycles = 0;
    bit watchdog_armed  = 1'b0;

    test_harness i_test_harness (
        .clock    (clock),
        .arst_n   (arst_n),
        .test_in  (test_in),
        .shift_en (shift_en),
        .update   (update),
        .capture  (capture),
        .test_out (test_out)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

// ------------------------------------------------------------
// Stimulus file

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          fields;
        string       token;
        string       rest;
        logic [31:0] op, sa, sb, ds, efa, efb, wef, da, db;
        logic [31:0] ewd, era, erb, ewr, eex, est;
        ok = 1'b1;
        fd = $fopen("verification/harness_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file verification/harness_stimulus.txt could not be opened");
            ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", token) == 1) begin
                if (token.getc(0) == "#") begin
                    void'($fgets(rest, fd));
                end else begin
                    fields = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     op, sa, sb, ds, efa, efb, wef, da, db,
                                     ewd, era, erb, ewr, eex, est);
                    if (fields != 15) begin
                        $display("Stimulus line for %s is missing fields", token);
                        ok = 1'b0;
                        break;
                    end
                    name_q.push_back(token);
                    // Same order as the scan vector, opcode on top
                    stim_q.push_back({op[1:0], sa[1:0], sb[1:0], ds[1:0],
                                      efa[3:0], efb[3:0], wef[3:0], da, db});
                    exp_write_data_q.push_back(ewd[7:0]);
                    exp_rden_a_q.push_back(era[3:0]);
                    exp_rden_b_q.push_back(erb[3:0]);
                    exp_wren_q.push_back(ewr[3:0]);
                    exp_exec_q.push_back(eex[7:0]);
                    exp_stall_q.push_back(est[7:0]);
                end
            end
            $fclose(fd);
            if (name_q.size() == 0) begin
                $display("Stimulus file holds no test vectors");
                ok = 1'b0;
            end
        end
    endtask

// ------------------------------------------------------------
// Scan access, all inputs change on the falling edge

    // Occasional idle cycles with the chain frozen
    task automatic insert_gap();
        shift_en = 1'b0;
        if (($urandom % 8) == 0) begin
            repeat (1 + ($urandom % 2)) @(negedge clock);
        end
    endtask

    task automatic shift_in_vector(input logic [harness_pkg::input_width-1:0] vec);
        for (int i = harness_pkg::input_width - 1; i >= 0; i--) begin
            insert_gap();
            test_in  = vec[i];
            shift_en = 1'b1;
            @(negedge clock);
        end
        shift_en = 1'b0;
        test_in  = 1'b0;
    endtask

    task automatic pulse_update();
        update = 1'b1;
        @(negedge clock);
        update = 1'b0;
        repeat (3) @(negedge clock);
    endtask

    task automatic pulse_capture();
        capture = 1'b1;
        @(negedge clock);
        capture = 1'b0;
    endtask

    // test_out already holds the top bit after capture
    task automatic shift_out_response(output logic [harness_pkg::output_width-1:0] resp);
        for (int i = harness_pkg::output_width - 1; i >= 0; i--) begin
            resp[i] = test_out;
            if (i > 0) begin
                insert_gap();
                shift_en = 1'b1;
                @(negedge clock);
            end
        end
        shift_en = 1'b0;
    endtask

// ------------------------------------------------------------
// Checks

    task automatic check_field(input string test_name, input string field,
                               input logic [7:0] expected, input logic [7:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name, field, expected, actual);
            error_count++;
        end
    endtask

    // Response layout: write_data, rden_a, rden_b, wren, exec, stall, 7 pad bits
    task automatic check_response(input string test_name,
                                  input logic [harness_pkg::output_width-1:0] resp,
                                  input logic [7:0] wd, input logic [3:0] ra,
                                  input logic [3:0] rb, input logic [3:0] wr,
                                  input logic [7:0] ex, input logic [7:0] st);
        check_field(test_name, "write_data", wd, resp[42:35]);
        check_field(test_name, "rden_a", {4'h0, ra}, {4'h0, resp[34:31]});
        check_field(test_name, "rden_b", {4'h0, rb}, {4'h0, resp[30:27]});
        check_field(test_name, "wren", {4'h0, wr}, {4'h0, resp[26:23]});
        check_field(test_name, "exec_count", ex, resp[22:15]);
        check_field(test_name, "stall_count", st, resp[14:7]);
        check_field(test_name, "pad", 8'h00, {1'b0, resp[6:0]});
    endtask

    task automatic check_reset_response();
        logic [harness_pkg::output_width-1:0] resp;
        pulse_capture();
        shift_out_response(resp);
        check_response("reset_response", resp, 8'h00, 4'h0, 4'h0, 4'h0, 8'h00, 8'h00);
    endtask

    task automatic run_vector(input int index);
        logic [harness_pkg::output_width-1:0] resp;
        shift_in_vector(stim_q[index]);
        pulse_update();
        pulse_capture();
        shift_out_response(resp);
        check_response(name_q[index], resp, exp_write_data_q[index], exp_rden_a_q[index],
                       exp_rden_b_q[index], exp_wren_q[index], exp_exec_q[index],
                       exp_stall_q[index]);
    endtask

// ------------------------------------------------------------
// Watchdog

    initial begin
        wait (watchdog_armed);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired: run did not finish within %0d clock cycles",
                 watchdog_cycles);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("test failed");
        $finish;
    end

// ------------------------------------------------------------
// Main sequence

    initial begin
        bit          load_ok;
        int unsigned seed_value;
        arst_n     = 1'b0;
        test_in    = 1'b0;
        shift_en   = 1'b0;
        update     = 1'b0;
        capture    = 1'b0;
        seed_value = 25396;
        void'($urandom(seed_value));

        load_stimulus(load_ok);
        if (load_ok) begin
            // Reset check counts as one extra vector
            watchdog_cycles = (name_q.size() + 1) * 200;
            watchdog_armed  = 1'b1;
        end

        repeat (2) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        if (load_ok) begin
            check_reset_response();
            foreach (name_q[i]) begin
                run_vector(i);
            end
        end else begin
            error_count++;
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== hw/test_harness.sv ====
`timescale 1ns/1ps

module test_harness (
    input  logic clock,
    input  logic arst_n,
    input  logic test_in,
    input  logic shift_en,
    input  logic update,
    input  logic capture,
    output logic test_out
);

    logic [harness_pkg::input_width-1:0]    vector;
    logic [harness_pkg::output_width-1:0]   response;
    logic                                   step;

    logic [harness_pkg::opcode_width-1:0]   opcode_bits;
    logic [harness_pkg::port_sel_width-1:0] src_a;
    logic [harness_pkg::port_sel_width-1:0] src_b;
    logic [harness_pkg::port_sel_width-1:0] dst;
    logic [harness_pkg::io_port_count-1:0]  read_ef_a;
    logic [harness_pkg::io_port_count-1:0]  read_ef_b;
    logic [harness_pkg::io_port_count-1:0]  write_ef;
    logic [harness_pkg::bank_width-1:0]     read_data_a;
    logic [harness_pkg::bank_width-1:0]     read_data_b;

    logic [harness_pkg::word_width-1:0]     write_data;
    logic [harness_pkg::io_port_count-1:0]  rden_a;
    logic [harness_pkg::io_port_count-1:0]  rden_b;
    logic [harness_pkg::io_port_count-1:0]  wren;
    logic [harness_pkg::count_width-1:0]    exec_count;
    logic [harness_pkg::count_width-1:0]    stall_count;

// ------------------------------------------------------------
// Vector packing, opcode on top

    assign {opcode_bits, src_a, src_b, dst, read_ef_a, read_ef_b, write_ef,
            read_data_a, read_data_b} = vector;

    assign response = {write_data, rden_a, rden_b, wren, exec_count, stall_count,
                       {harness_pkg::output_pad_width{1'b0}}};

// ------------------------------------------------------------
// Scan registers

    harness_input_register i_harness_input_register (
        .clock    (clock),
        .arst_n   (arst_n),
        .test_in  (test_in),
        .shift_en (shift_en),
        .update   (update),
        .vector   (vector),
        .step     (step)
    );

    harness_output_register i_harness_output_register (
        .clock    (clock),
        .arst_n   (arst_n),
        .shift_en (shift_en),
        .capture  (capture),
        .response (response),
        .test_out (test_out)
    );

// ------------------------------------------------------------
// Core

    io_port_core i_io_port_core (
        .clock       (clock),
        .arst_n      (arst_n),
        .step        (step),
        .opcode      (harness_pkg::opcode_t'(opcode_bits)),
        .src_a       (src_a),
        .src_b       (src_b),
        .dst         (dst),
        .read_ef_a   (read_ef_a),
        .read_ef_b   (read_ef_b),
        .write_ef    (write_ef),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b),
        .write_data  (write_data),
        .rden_a      (rden_a),
        .rden_b      (rden_b),
        .wren        (wren),
        .exec_count  (exec_count),
        .stall_count (stall_count)
    );

endmodule

// ==== hw/io_port_core.sv ====
`timescale 1ns/1ps

module io_port_core (
    input  logic                                   clock,
    input  logic                                   arst_n,
    input  logic                                   step,
    input  harness_pkg::opcode_t                   opcode,
    input  logic [harness_pkg::port_sel_width-1:0] src_a,
    input  logic [harness_pkg::port_sel_width-1:0] src_b,
    input  logic [harness_pkg::port_sel_width-1:0] dst,
    input  logic [harness_pkg::io_port_count-1:0]  read_ef_a,
    input  logic [harness_pkg::io_port_count-1:0]  read_ef_b,
    input  logic [harness_pkg::io_port_count-1:0]  write_ef,
    input  logic [harness_pkg::bank_width-1:0]     read_data_a,
    input  logic [harness_pkg::bank_width-1:0]     read_data_b,
    output logic [harness_pkg::word_width-1:0]     write_data,
    output logic [harness_pkg::io_port_count-1:0]  rden_a,
    output logic [harness_pkg::io_port_count-1:0]  rden_b,
    output logic [harness_pkg::io_port_count-1:0]  wren,
    output logic [harness_pkg::count_width-1:0]    exec_count,
    output logic [harness_pkg::count_width-1:0]    stall_count
);

    logic [harness_pkg::word_width-1:0] operand_a;
    logic [harness_pkg::word_width-1:0] operand_b;
    logic                               ready;
    logic                               issue;

    function automatic logic [harness_pkg::io_port_count-1:0] one_hot(
        input logic [harness_pkg::port_sel_width-1:0] index
    );
        logic [harness_pkg::io_port_count-1:0] decoded;
        decoded        = '0;
        decoded[index] = 1'b1;
        return decoded;
    endfunction

// ------------------------------------------------------------
// Operand selection

    assign operand_a = read_data_a[src_a*harness_pkg::word_width +: harness_pkg::word_width];
    assign operand_b = read_data_b[src_b*harness_pkg::word_width +: harness_pkg::word_width];

// ------------------------------------------------------------
// Port flags

    // Sources must hold data, destination must have space
    assign ready = read_ef_a[src_a] & read_ef_b[src_b] & write_ef[dst];
    assign issue = step & ready;

// ------------------------------------------------------------
// Enables and counters

    // Enables stay up until the next step so they can be captured
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rden_a      <= '0;
            rden_b      <= '0;
            wren        <= '0;
            exec_count  <= '0;
            stall_count <= '0;
        end else if (step) begin
            if (ready) begin
                rden_a     <= one_hot(src_a);
                rden_b     <= one_hot(src_b);
                wren       <= one_hot(dst);
                exec_count <= exec_count + 1'b1;
            end else begin
                rden_a      <= '0;
                rden_b      <= '0;
                wren        <= '0;
                stall_count <= stall_count + 1'b1;
            end
        end
    end

// ------------------------------------------------------------
// ALU

    // A stall leaves the result, and so write_data, unchanged
    triadic_alu i_triadic_alu (
        .clock     (clock),
        .arst_n    (arst_n),
        .issue     (issue),
        .opcode    (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (write_data)
    );

endmodule

// ==== hw/triadic_alu.sv ====
`timescale 1ns/1ps

module triadic_alu (
    input  logic                               clock,
    input  logic                               arst_n,
    input  logic                               issue,
    input  harness_pkg::opcode_t               opcode,
    input  logic [harness_pkg::word_width-1:0] operand_a,
    input  logic [harness_pkg::word_width-1:0] operand_b,
    output logic [harness_pkg::word_width-1:0] result
);

    logic [harness_pkg::word_width-1:0] result_next;

// ------------------------------------------------------------
// Operation

    // Add and sub drop the carry, so they wrap at the word size
    always_comb begin
        unique case (opcode)
            harness_pkg::op_add: begin
                result_next = operand_a + operand_b;
            end
            harness_pkg::op_sub: begin
                result_next = operand_a - operand_b;
            end
            harness_pkg::op_and: begin
                result_next = operand_a & operand_b;
            end
            harness_pkg::op_xor: begin
                result_next = operand_a ^ operand_b;
            end
            default: begin
                result_next = '0;
            end
        endcase
    end

// ------------------------------------------------------------
// Result register, holds between issues

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (issue) begin
            result <= result_next;
        end
    end

endmodule

// ==== hw/harness_output_register.sv ====
`timescale 1ns/1ps

module harness_output_register (
    input  logic                                 clock,
    input  logic                                 arst_n,
    input  logic                                 shift_en,
    input  logic                                 capture,
    input  logic [harness_pkg::output_width-1:0] response,
    output logic                                 test_out
);

    logic [harness_pkg::output_width-1:0] capture_reg;

// ------------------------------------------------------------
// Parallel load, then shift toward the top bit

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            capture_reg <= '0;
        end else if (capture) begin
            capture_reg <= response;
        end else if (shift_en) begin
            capture_reg <= {capture_reg[harness_pkg::output_width-2:0], 1'b0};
        end
    end

    // MSB leaves first
    assign test_out = capture_reg[harness_pkg::output_width-1];

endmodule

// ==== hw/harness_input_register.sv ====
`timescale 1ns/1ps

module harness_input_register (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                test_in,
    input  logic                                shift_en,
    input  logic                                update,
    output logic [harness_pkg::input_width-1:0] vector,
    output logic                                step
);

    logic [harness_pkg::input_width-1:0] chain;

// ------------------------------------------------------------
// Serial chain, MSB enters first

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            chain <= '0;
        end else if (shift_en) begin
            chain <= {chain[harness_pkg::input_width-2:0], test_in};
        end
    end

// ------------------------------------------------------------
// Shadow register and step strobe

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            vector <= '0;
        end else if (update) begin
            vector <= chain;
        end
    end

    // One cycle after the update edge
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            step <= 1'b0;
        end else begin
            step <= update;
        end
    end

endmodule

// ==== hw/harness_pkg.sv ====
package harness_pkg;

// ------------------------------------------------------------
// Data path

    localparam int word_width     = 8;
    localparam int io_port_count  = 4;
    localparam int port_sel_width = 2;
    localparam int count_width    = 8;

    // One bank of read data, all ports packed
    localparam int bank_width = io_port_count * word_width;

// ------------------------------------------------------------
// Opcodes

    localparam int opcode_width = 2;

    typedef enum logic [opcode_width-1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_and = 2'd2,
        op_xor = 2'd3
    } opcode_t;

// ------------------------------------------------------------
// Scan vectors

    // Opcode, three port selects, three flag sets, two read banks
    localparam int input_width = opcode_width
                               + (3 * port_sel_width)
                               + (3 * io_port_count)
                               + (2 * bank_width);

    // Zero bits below the stall counter
    localparam int output_pad_width = 7;

    // Write data, three enable sets, two counters, pad
    localparam int output_width = word_width
                                + (3 * io_port_count)
                                + (2 * count_width)
                                + output_pad_width;

endpackage
